// File: logic/blur_cfg_pkg.sv
`default_nettype none

package blur_cfg_pkg;

    // Kernel selection held in REG_CTRL bits 1:0
    typedef enum logic [1:0] {
        KM_BYPASS  = 2'd0,
        KM_3X3     = 2'd1,
        KM_5X5     = 2'd2,
        // Spare encoding that runs the 5x5 kernel
        KM_5X5_ALT = 2'd3
    } kernel_mode_e;

    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_FRAMES = 2'd1
    } reg_addr_e;

    // Wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: logic/blur_csr.sv
`timescale 1ns/1ps
`default_nettype none

module blur_csr (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  blur_cfg_pkg::wb_req_t  wb_req,
    output blur_cfg_pkg::wb_rsp_t        wb_rsp,
    input  wire                          frame_done,
    output blur_cfg_pkg::kernel_mode_e   mode
);

    import blur_cfg_pkg::*;

    logic        req_hit;
    logic [15:0] frame_count;
    logic [15:0] rd_data;

    // New request while no ack is outstanding
    assign req_hit = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    always_comb begin
        case (reg_addr_e'(wb_req.adr))
            REG_CTRL:   rd_data = {14'd0, mode};
            REG_FRAMES: rd_data = frame_count;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp.ack  <= 1'b0;
            mode        <= KM_BYPASS;
            frame_count <= '0;
        end else begin
            // Ack lasts one cycle and the host drops stb once it sees it
            wb_rsp.ack <= req_hit;
            if (req_hit && !wb_req.we) begin
                wb_rsp.dat_r <= rd_data;
            end
            // Mode lands on the ack edge, so the next accepted beat sees it
            if (req_hit && wb_req.we && wb_req.adr == REG_CTRL) begin
                mode <= kernel_mode_e'(wb_req.dat_w[1:0]);
            end
            if (frame_done) begin
                frame_count <= frame_count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/blur_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module blur_filter_top #(
    parameter int IMG_WIDTH = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    output logic                         in_ready,
    input  wire  video_pkg::stream_beat_t in_beat,
    output logic                         out_valid,
    input  wire                          out_ready,
    output video_pkg::stream_beat_t      out_beat,
    input  wire  blur_cfg_pkg::wb_req_t  wb_req,
    output blur_cfg_pkg::wb_rsp_t        wb_rsp
);

    import blur_cfg_pkg::*;
    import video_pkg::*;

    kernel_mode_e mode;
    window_beat_t window;
    sum_beat_t    sums;
    logic         advance;
    logic         frame_done;

    // Whole pipeline moves together and an empty output slot never blocks it
    assign advance    = out_ready || !out_valid;
    assign in_ready   = advance;
    assign frame_done = out_valid && out_ready && out_beat.eop;

    blur_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .frame_done (frame_done),
        .mode       (mode)
    );

    pixel_window #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .mode     (mode),
        .window   (window)
    );

    blur_mac u_mac (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .window  (window),
        .sums    (sums)
    );

    blur_normalize u_norm (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .sums      (sums),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

endmodule

`default_nettype wire

// File: logic/blur_mac.sv
`timescale 1ns/1ps
`default_nettype none

module blur_mac (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          advance,
    input  wire  video_pkg::window_beat_t window,
    output video_pkg::sum_beat_t         sums
);

    import blur_cfg_pkg::*;
    import video_pkg::*;

    // Row sums peak at 18 * 15 = 270
    typedef logic [8:0] row_sum_t;

    typedef struct packed {
        logic                   valid;
        kernel_mode_e           mode;
        logic                   sop;
        logic                   eop;
        row_sum_t [2:0][4:0]    rows;
        pixel_t                 newest;
    } row_beat_t;

    localparam logic [2:0] WEIGHTS [5][5] = '{
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd3, 3'd4, 3'd4, 3'd4, 3'd3},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1}
    };

    row_beat_t s1_d;
    row_beat_t s1_q;
    sum_beat_t sum_d;
    logic      narrow;

    assign narrow = (window.mode == KM_3X3);

    // Stage one forms weighted row sums per channel
    always_comb begin : row_sums
        logic [2:0][3:0] pv;
        logic [2:0]      w;
        s1_d.valid  = window.valid;
        s1_d.mode   = window.mode;
        s1_d.sop    = window.sop;
        s1_d.eop    = window.eop;
        s1_d.newest = window.taps[4][4];
        s1_d.rows   = '0;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                pv = window.taps[r][c];
                // 3x3 keeps the centre of the table only
                if (narrow && (r == 0 || r == 4 || c == 0 || c == 4)) begin
                    w = 3'd0;
                end else begin
                    w = WEIGHTS[r][c];
                end
                for (int ch = 0; ch < 3; ch++) begin
                    s1_d.rows[ch][r] += pv[ch] * w;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_q.valid <= 1'b0;
        end else if (advance) begin
            s1_q <= s1_d;
        end
    end

    // Stage two folds rows into 10-bit channel totals
    always_comb begin
        sum_d.valid  = s1_q.valid;
        sum_d.mode   = s1_q.mode;
        sum_d.sop    = s1_q.sop;
        sum_d.eop    = s1_q.eop;
        sum_d.newest = s1_q.newest;
        for (int ch = 0; ch < 3; ch++) begin
            sum_d.sum[ch] = '0;
            for (int r = 0; r < 5; r++) begin
                sum_d.sum[ch] += s1_q.rows[ch][r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sums.valid <= 1'b0;
        end else if (advance) begin
            sums <= sum_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/blur_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module blur_normalize (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          advance,
    input  wire  video_pkg::sum_beat_t   sums,
    output logic                         out_valid,
    output video_pkg::stream_beat_t      out_beat
);

    import blur_cfg_pkg::*;
    import video_pkg::*;

    logic [2:0][3:0] narrow_pv;
    logic [2:0][3:0] wide_pv;
    pixel_t          px_d;

    // 3x3 weights sum to 32, 5x5 to 64
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            narrow_pv[ch] = sums.sum[ch][8:5];
            wide_pv[ch]   = sums.sum[ch][9:6];
        end
        case (sums.mode)
            KM_BYPASS: px_d = sums.newest;
            KM_3X3:    px_d = narrow_pv;
            default:   px_d = wide_pv;
        endcase
    end

    // Holds while the sink stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= sums.valid;
            out_beat  <= '{data: px_d, sop: sums.sop, eop: sums.eop};
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_window.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_window #(
    parameter int IMG_WIDTH = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          advance,
    input  wire                          in_valid,
    input  wire  video_pkg::stream_beat_t in_beat,
    input  wire  blur_cfg_pkg::kernel_mode_e mode,
    output video_pkg::window_beat_t      window
);

    import video_pkg::*;

    // Stored history plus the incoming sample spans the whole window
    localparam int DEPTH = 4 * IMG_WIDTH + 4;

    pixel_t       line [DEPTH];
    pixel_t       span [DEPTH + 1];
    window_beat_t win_d;
    logic         accept;

    assign accept = advance && in_valid;

    // span[0] is the incoming sample, span[n] the one n beats back
    always_comb begin
        span[0] = in_beat.data;
        for (int i = 0; i < DEPTH; i++) begin
            span[i + 1] = line[i];
        end
    end

    // History moves only on accepted beats
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                line[i] <= '0;
            end
        end else if (accept) begin
            for (int i = 0; i < DEPTH; i++) begin
                line[i] <= span[i];
            end
        end
    end

    // Tap (r,c) sits DEPTH - r*W - c beats back
    always_comb begin
        win_d.valid = in_valid;
        win_d.mode  = mode;
        win_d.sop   = in_beat.sop;
        win_d.eop   = in_beat.eop;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                win_d.taps[r][c] = span[DEPTH - r * IMG_WIDTH - c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window.valid <= 1'b0;
        end else if (advance) begin
            window <= win_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/video_pkg.sv
`default_nettype none

package video_pkg;

    import blur_cfg_pkg::*;

    typedef logic [3:0] channel_t;

    // RGB444 with red in the top bits
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    typedef struct packed {
        pixel_t data;
        logic   sop;
        logic   eop;
    } stream_beat_t;

    // Tap [0][0] is the oldest sample, tap [4][4] the newest
    typedef struct packed {
        logic                   valid;
        kernel_mode_e           mode;
        logic                   sop;
        logic                   eop;
        pixel_t [0:4][0:4]      taps;
    } window_beat_t;

    typedef logic [9:0] chan_sum_t;

    // Sum index 2 is red, 1 green, 0 blue
    typedef struct packed {
        logic                   valid;
        kernel_mode_e           mode;
        logic                   sop;
        logic                   eop;
        chan_sum_t [2:0]        sum;
        pixel_t                 newest;
    } sum_beat_t;

endpackage

`default_nettype wire

// File: sim.f
logic/blur_cfg_pkg.sv
logic/video_pkg.sv
logic/blur_csr.sv
logic/pixel_window.sv
logic/blur_mac.sv
logic/blur_normalize.sv
logic/blur_filter_top.sv
tests/blur_props.sv
tests/blur_filter_tb.sv

// File: tests/blur_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module blur_filter_tb;

    import blur_cfg_pkg::*;
    import video_pkg::*;

    localparam int IMG_W       = 16;
    localparam int FRAME_BEATS = IMG_W * 8;
    localparam int TOTAL_BEATS = 7 * FRAME_BEATS;
    localparam int TIMEOUT_CYC = TOTAL_BEATS * 20 + 2000;
    localparam int DRAIN_CYC   = 64;
    localparam logic [31:0] LFSR_SEED = 32'h4ab1_6c09;
    localparam int KERNEL [5][5] = '{
        '{1, 2, 3, 2, 1}, '{2, 3, 4, 3, 2}, '{3, 4, 4, 4, 3}, '{2, 3, 4, 3, 2}, '{1, 2, 3, 2, 1}
    };

    typedef struct packed {
        stream_beat_t beat;
        kernel_mode_e mode;
    } exp_entry_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t in_beat;
    logic         out_valid;
    logic         out_ready;
    stream_beat_t out_beat;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;

    logic [31:0]  lfsr;
    logic [31:0]  sink_lfsr;
    logic         random_ready;
    kernel_mode_e model_mode;
    pixel_t       hist [TOTAL_BEATS];
    int           hist_len;
    int           out_count;
    int           frames_sent;
    string        test_name;
    exp_entry_t   exp_q [$];

    blur_filter_top #(.IMG_WIDTH(IMG_W)) uut (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
        .out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Window over all accepted beats with the newest at tap (4,4)
    function automatic pixel_t expected_pixel(input int idx, input kernel_mode_e m);
        int     acc_r;
        int     acc_g;
        int     acc_b;
        int     src;
        int     w;
        int     sh;
        pixel_t p;
        pixel_t res;
        if (m == KM_BYPASS) begin
            return hist[idx];
        end
        acc_r = 0;
        acc_g = 0;
        acc_b = 0;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                src = idx - (4 * IMG_W + 4 - r * IMG_W - c);
                w = KERNEL[r][c];
                if (m == KM_3X3 && (r == 0 || r == 4 || c == 0 || c == 4)) begin
                    w = 0;
                end
                p = (src >= 0) ? hist[src] : '0;
                acc_r += p.red * w;
                acc_g += p.green * w;
                acc_b += p.blue * w;
            end
        end
        sh = (m == KM_3X3) ? 5 : 6;
        res.red   = channel_t'(acc_r >> sh);
        res.green = channel_t'(acc_g >> sh);
        res.blue  = channel_t'(acc_b >> sh);
        return res;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_beat(input string what, input stream_beat_t expected,
                              input stream_beat_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected data %h sop %b eop %b, actual data %h sop %b eop %b",
                     what, expected.data, expected.sop, expected.eop,
                     actual.data, actual.sop, actual.eop);
            stop_on_failure("Output beat differs from the reference model");
        end
    endtask

    task automatic check_reg(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
            stop_on_failure("Register read returned a wrong value");
        end
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [15:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
        do @(posedge clk); while (!wb_rsp.ack);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [15:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 16'd0};
        do @(posedge clk); while (!wb_rsp.ack);
        data = wb_rsp.dat_r;
        #1;
        wb_req = '0;
    endtask

    task automatic send_beat(input stream_beat_t b, input bit gaps);
        while (gaps && rand_bits(2) == 2'd0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        in_beat  = b;
        in_valid = 1'b1;
        do @(posedge clk); while (!in_ready);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input bit gaps);
        stream_beat_t b;
        for (int i = 0; i < FRAME_BEATS; i++) begin
            b.data = pixel_t'(rand_bits(12));
            b.sop  = (i == 0);
            b.eop  = (i == FRAME_BEATS - 1);
            send_beat(b, gaps);
        end
        frames_sent++;
    endtask

    // Drain the pipeline and compare the frame counter with the frames sent
    task automatic finish_test();
        logic [15:0] rd;
        int          waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYC) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            stop_on_failure($sformatf("%s left %0d accepted beats inside the DUT",
                                      test_name, exp_q.size()));
        end else begin
            wb_read(REG_FRAMES, rd);
            check_reg({test_name, " frame count"}, 16'(frames_sent), rd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Sink readiness is random only where a test asks for it
    initial begin : sink
        logic [1:0] draw;
        forever begin
            @(posedge clk);
            #1;
            if (random_ready) begin
                for (int i = 0; i < 2; i++) begin
                    sink_lfsr = lfsr_step(sink_lfsr);
                    draw = {draw[0], sink_lfsr[0]};
                end
                out_ready = (draw != 2'd0);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Watchdog expired, the DUT stopped moving beats");
        $display("Test failures found");
        $fatal(1, "Timeout");
    end

    // Scoreboard checks outputs first, then inputs, then the mode seen on the bus
    always @(posedge clk) begin : monitor
        exp_entry_t e;
        if (rst_n) begin
            if (uut.u_props.violations != 0) begin
                stop_on_failure("A bound stream or Wishbone assertion failed");
            end else begin
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        stop_on_failure("The DUT sent a beat that was never accepted");
                    end else begin
                        e = exp_q.pop_front();
                        check_beat($sformatf("%s beat %0d mode %0d",
                                             test_name, out_count, e.mode),
                                   e.beat, out_beat);
                        out_count++;
                    end
                end
                if (in_valid && in_ready) begin
                    hist[hist_len] = in_beat.data;
                    e.beat = '{data: expected_pixel(hist_len, model_mode),
                               sop: in_beat.sop, eop: in_beat.eop};
                    e.mode = model_mode;
                    exp_q.push_back(e);
                    hist_len++;
                end
                // Write lands on the ack edge so beats accepted here keep the old mode
                if (wb_req.cyc && wb_req.stb && wb_req.we && !wb_rsp.ack
                        && wb_req.adr == REG_CTRL) begin
                    model_mode = kernel_mode_e'(wb_req.dat_w[1:0]);
                end
            end
        end
    end

    initial begin : main
        logic [15:0] rd;
        lfsr         = LFSR_SEED;
        sink_lfsr    = LFSR_SEED;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_beat      = '0;
        out_ready    = 1'b1;
        wb_req       = '0;
        random_ready = 1'b0;
        model_mode   = KM_BYPASS;
        hist_len     = 0;
        out_count    = 0;
        frames_sent  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "registers";
        wb_read(REG_CTRL, rd);
        check_reg({test_name, " ctrl after reset"}, 16'(KM_BYPASS), rd);
        wb_read(REG_FRAMES, rd);
        check_reg({test_name, " frames after reset"}, 16'd0, rd);
        wb_write(REG_CTRL, 16'(KM_5X5));
        wb_read(REG_CTRL, rd);
        check_reg({test_name, " ctrl readback"}, 16'(KM_5X5), rd);

        test_name = "bypass";
        wb_write(REG_CTRL, 16'(KM_BYPASS));
        send_frame(1'b0);
        send_frame(1'b0);
        finish_test();

        test_name = "kernel 3x3";
        wb_write(REG_CTRL, 16'(KM_3X3));
        send_frame(1'b0);
        finish_test();

        test_name = "kernel 5x5";
        wb_write(REG_CTRL, 16'(KM_5X5));
        send_frame(1'b0);
        wb_write(REG_CTRL, 16'(KM_5X5_ALT));
        send_frame(1'b0);
        finish_test();

        // Gaps on both sides and a mode switch mid-stream
        test_name    = "backpressure";
        random_ready = 1'b1;
        fork
            begin
                send_frame(1'b1);
                send_frame(1'b1);
            end
            begin
                repeat (150) @(posedge clk);
                #1;
                wb_write(REG_CTRL, 16'(KM_3X3));
            end
        join
        random_ready = 1'b0;
        finish_test();

        if (uut.u_props.violations != 0) begin
            stop_on_failure("A bound stream or Wishbone assertion failed");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/blur_props.sv
`timescale 1ns/1ps
`default_nettype none

module blur_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          out_valid,
    input wire                          out_ready,
    input wire video_pkg::stream_beat_t out_beat,
    input wire blur_cfg_pkg::wb_req_t   wb_req,
    input wire blur_cfg_pkg::wb_rsp_t   wb_rsp
);

    import blur_cfg_pkg::*;
    import video_pkg::*;

    // Failed assertions so far
    int unsigned violations = 0;

    assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            violations++;
        end

    // Stalled output must hold
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin
            $error("Output beat changed while stalled");
            violations++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("Wishbone ack held for two cycles");
            violations++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("Wishbone ack without a request");
            violations++;
        end

endmodule

bind blur_filter_top blur_props u_props (
    .clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out_ready(out_ready),
    .out_beat(out_beat), .wb_req(wb_req), .wb_rsp(wb_rsp)
);

`default_nettype wire
